// ==== Bender.yml ====
package:
  name: noc_router

sources:
  - include_dirs:
      - include
    files:
      - logic/noc_router_pkg.sv
      - logic/credit_release_gen.sv
      - logic/noc_input_port.sv
      - logic/noc_vc_sw_alloc.sv
      - logic/noc_output_port.sv
      - logic/noc_router.sv
      - target: simulation
        files:
          - verif/noc_tb_clock.sv
          - verif/noc_router_checker.sv
          - verif/noc_router_tb.sv

// ==== include/noc_router_defines.svh ====
`ifndef NOC_ROUTER_DEFINES_SVH
`define NOC_ROUTER_DEFINES_SVH

// router geometry
`define NOC_P 5
`define NOC_V 2

// flits per vc buffer, also the starting credit per output vc
`define NOC_LB 4

`define NOC_FW 32
`define NOC_AW 4

// port indices, mesh directions
`define NOC_PORT_LOCAL 0
`define NOC_PORT_EAST 1
`define NOC_PORT_NORTH 2
`define NOC_PORT_WEST 3
`define NOC_PORT_SOUTH 4

`endif

// ==== logic/credit_release_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_router_defines.svh"

module credit_release_gen (
	input  logic clk,
	input  logic reset,
	input  logic en,
	output logic credit_out
);

	localparam int CW = $clog2(`NOC_LB + 1);

	logic [CW-1:0] count;
	logic advance;

	// start on en from idle, then run up to a full buffer
	assign advance = (en && count == '0) || (count != '0 && count != CW'(`NOC_LB));

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			credit_out <= 1'b0;
		end else begin
			credit_out <= advance;
			if (advance)
				count <= count + 1'b1;
			else if (count == CW'(`NOC_LB))
				count <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/noc_input_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_router_defines.svh"

module noc_input_port
	import noc_router_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic [`NOC_AW-1:0] current_x,
	input  logic [`NOC_AW-1:0] current_y,
	input  logic flit_wr,
	input  logic [VC_W-1:0] flit_vc,
	input  flit_t flit_in,
	input  vc_grant_t grant [`NOC_V],
	output vc_req_t req [`NOC_V],
	output flit_t head_flit [`NOC_V],
	output logic [`NOC_V-1:0] credit_out
);

	localparam int PW = $clog2(`NOC_LB);
	localparam int CW = $clog2(`NOC_LB + 1);

	// dimension order, x first then y
	function automatic logic [`NOC_P-1:0] xy_route(
		input flit_t f,
		input logic [`NOC_AW-1:0] cx,
		input logic [`NOC_AW-1:0] cy
	);
		logic [`NOC_P-1:0] r;
		r = '0;
		if (f.head.dst_x > cx)
			r[`NOC_PORT_EAST] = 1'b1;
		else if (f.head.dst_x < cx)
			r[`NOC_PORT_WEST] = 1'b1;
		else if (f.head.dst_y > cy)
			r[`NOC_PORT_NORTH] = 1'b1;
		else if (f.head.dst_y < cy)
			r[`NOC_PORT_SOUTH] = 1'b1;
		else
			r[`NOC_PORT_LOCAL] = 1'b1;
		return r;
	endfunction

	for (genvar v = 0; v < `NOC_V; v++) begin : g_vc
		flit_t mem [`NOC_LB];
		logic [PW-1:0] wr_ptr;
		logic [PW-1:0] rd_ptr;
		logic [CW-1:0] count;
		logic push;
		logic pop;
		logic [`NOC_P-1:0] route_q;
		logic [VC_W-1:0] ovc_q;
		flit_type_e head_type;

		assign push = flit_wr && (flit_vc == VC_W'(v));
		// registered grant, flit leaves on this edge
		assign pop = grant[v].granted;
		assign head_flit[v] = mem[rd_ptr];
		assign head_type = mem[rd_ptr].head.ftype;
		// one freed slot per pop
		assign credit_out[v] = pop;

		always_ff @(posedge clk) begin
			if (reset) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end else begin
				if (push)
					wr_ptr <= (wr_ptr == PW'(`NOC_LB - 1)) ? '0 : wr_ptr + 1'b1;
				if (pop)
					rd_ptr <= (rd_ptr == PW'(`NOC_LB - 1)) ? '0 : rd_ptr + 1'b1;
				count <= count + CW'(push) - CW'(pop);
			end
		end

		always_ff @(posedge clk) begin
			if (push)
				mem[wr_ptr] <= flit_in;
		end

		// route and output vc held until the tail goes
		always_ff @(posedge clk) begin
			if (reset) begin
				route_q <= '0;
				ovc_q <= '0;
			end else if (pop && head_type == HEAD) begin
				route_q <= grant[v].dest;
				ovc_q <= grant[v].ovc;
			end
		end

		always_comb begin
			// the flit being popped must not ask twice
			req[v].valid = (count != '0) && !pop;
			req[v].new_vc = (head_type == HEAD) || (head_type == SINGLE);
			req[v].dest = req[v].new_vc ? xy_route(mem[rd_ptr], current_x, current_y) : route_q;
			req[v].ovc = ovc_q;
			req[v].tail = (head_type == TAIL) || (head_type == SINGLE);
		end

		a_no_overflow: assert property (
			@(posedge clk) disable iff (reset) push |-> (count != CW'(`NOC_LB))
		);
	end

endmodule

`default_nettype wire

// ==== logic/noc_output_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_router_defines.svh"

module noc_output_port
	import noc_router_pkg::*;
#(
	parameter int PORT = 0
)(
	input  logic clk,
	input  logic reset,
	input  vc_grant_t grant [`NOC_P][`NOC_V],
	input  flit_t head_flit [`NOC_P][`NOC_V],
	input  logic [`NOC_V-1:0] credit_in,
	output logic [`NOC_V-1:0] ovc_free,
	output logic [`NOC_V-1:0] credit_avail,
	output flit_chan_t chan_flit
);

	localparam int CW = $clog2(`NOC_LB + 1);

	logic hit;
	flit_t sel_flit;
	logic [VC_W-1:0] sel_ovc;
	logic sel_head;
	logic sel_tail;
	logic [`NOC_V-1:0] owned;
	logic [CW-1:0] credit_cnt [`NOC_V];
	logic out_wr;
	logic [VC_W-1:0] out_vc;
	flit_t out_flit;

	// crossbar column for this port
	always_comb begin
		hit = 1'b0;
		sel_flit = '0;
		sel_ovc = '0;
		sel_tail = 1'b0;
		for (int p = 0; p < `NOC_P; p++) begin
			for (int v = 0; v < `NOC_V; v++) begin
				if (grant[p][v].granted && grant[p][v].dest[PORT]) begin
					hit = 1'b1;
					sel_flit = head_flit[p][v];
					sel_ovc = grant[p][v].ovc;
					sel_tail = grant[p][v].tail;
				end
			end
		end
	end

	assign sel_head = hit && (sel_flit.head.ftype == HEAD || sel_flit.head.ftype == SINGLE);

	// a grant in flight already counts against the vc
	always_comb begin
		for (int v = 0; v < `NOC_V; v++) begin
			ovc_free[v] = !owned[v] && !(sel_head && sel_ovc == VC_W'(v));
			credit_avail[v] = credit_cnt[v] > CW'(hit && sel_ovc == VC_W'(v));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_wr <= 1'b0;
			owned <= '0;
			for (int v = 0; v < `NOC_V; v++)
				credit_cnt[v] <= CW'(`NOC_LB);
		end else begin
			out_wr <= hit;
			for (int v = 0; v < `NOC_V; v++) begin
				credit_cnt[v] <= credit_cnt[v] + CW'(credit_in[v])
					- CW'(hit && sel_ovc == VC_W'(v));
				if (sel_head && sel_ovc == VC_W'(v))
					owned[v] <= 1'b1;
				// single flit: tail clear comes last
				if (hit && sel_tail && sel_ovc == VC_W'(v))
					owned[v] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hit) begin
			out_vc <= sel_ovc;
			out_flit <= sel_flit;
		end
	end

	assign chan_flit.flit_wr = out_wr;
	assign chan_flit.vc = out_vc;
	assign chan_flit.flit = out_flit;
	assign chan_flit.credit = '0;

	for (genvar v = 0; v < `NOC_V; v++) begin : g_chk
		a_credit_bound: assert property (
			@(posedge clk) disable iff (reset) credit_cnt[v] <= CW'(`NOC_LB)
		);
	end

endmodule

`default_nettype wire

// ==== logic/noc_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_router_defines.svh"

module noc_router
	import noc_router_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic [`NOC_AW-1:0] current_x,
	input  logic [`NOC_AW-1:0] current_y,
	input  logic [`NOC_V-1:0] credit_release_en,
	input  flit_chan_t chan_in [`NOC_P],
	output flit_chan_t chan_out [`NOC_P]
);

	vc_req_t req [`NOC_P][`NOC_V];
	vc_grant_t grant [`NOC_P][`NOC_V];
	flit_t head_flit [`NOC_P][`NOC_V];
	logic [`NOC_V-1:0] ovc_free [`NOC_P];
	logic [`NOC_V-1:0] credit_avail [`NOC_P];
	logic [`NOC_V-1:0] iport_credit [`NOC_P];
	flit_chan_t out_chan [`NOC_P];
	logic [`NOC_V-1:0] release_credit;

	for (genvar i = 0; i < `NOC_P; i++) begin : g_port
		logic [`NOC_V-1:0] extra_credit;

		noc_input_port u_in (
			.clk(clk),
			.reset(reset),
			.current_x(current_x),
			.current_y(current_y),
			.flit_wr(chan_in[i].flit_wr),
			.flit_vc(chan_in[i].vc),
			.flit_in(chan_in[i].flit),
			.grant(grant[i]),
			.req(req[i]),
			.head_flit(head_flit[i]),
			.credit_out(iport_credit[i])
		);

		noc_output_port #(
			.PORT(i)
		) u_out (
			.clk(clk),
			.reset(reset),
			.grant(grant),
			.head_flit(head_flit),
			.credit_in(chan_in[i].credit),
			.ovc_free(ovc_free[i]),
			.credit_avail(credit_avail[i]),
			.chan_flit(out_chan[i])
		);

		// release credits only on the local port
		assign extra_credit = (i == `NOC_PORT_LOCAL) ? release_credit : '0;

		assign chan_out[i].flit_wr = out_chan[i].flit_wr;
		assign chan_out[i].vc = out_chan[i].vc;
		assign chan_out[i].flit = out_chan[i].flit;
		assign chan_out[i].credit = iport_credit[i] | extra_credit;
	end

	noc_vc_sw_alloc u_alloc (
		.clk(clk),
		.reset(reset),
		.req(req),
		.ovc_free(ovc_free),
		.credit_avail(credit_avail),
		.grant(grant)
	);

	for (genvar v = 0; v < `NOC_V; v++) begin : g_release
		credit_release_gen u_release (
			.clk(clk),
			.reset(reset),
			.en(credit_release_en[v]),
			.credit_out(release_credit[v])
		);
	end

endmodule

`default_nettype wire

// ==== logic/noc_router_pkg.sv ====
`default_nettype none

`include "noc_router_defines.svh"

package noc_router_pkg;

	localparam int VC_W = $clog2(`NOC_V);
	// what is left of the word after type and four coordinates
	localparam int HEAD_PW = `NOC_FW - 2 - 4 * `NOC_AW;

	typedef enum logic [1:0] {
		HEAD,
		BODY,
		TAIL,
		SINGLE
	} flit_type_e;

	typedef struct packed {
		flit_type_e ftype;
		logic [`NOC_AW-1:0] dst_x;
		logic [`NOC_AW-1:0] dst_y;
		logic [`NOC_AW-1:0] src_x;
		logic [`NOC_AW-1:0] src_y;
		logic [HEAD_PW-1:0] payload;
	} head_view_t;

	typedef struct packed {
		flit_type_e ftype;
		logic [`NOC_FW-3:0] payload;
	} body_view_t;

	// type field sits in the same bits in both views
	typedef union packed {
		head_view_t head;
		body_view_t body;
	} flit_t;

	// one link direction
	typedef struct packed {
		logic flit_wr;
		logic [VC_W-1:0] vc;
		flit_t flit;
		logic [`NOC_V-1:0] credit;
	} flit_chan_t;

	typedef struct packed {
		logic valid;
		logic [`NOC_P-1:0] dest;
		logic new_vc;
		logic [VC_W-1:0] ovc;
		logic tail;
	} vc_req_t;

	typedef struct packed {
		logic granted;
		logic [`NOC_P-1:0] dest;
		logic [VC_W-1:0] ovc;
		logic tail;
	} vc_grant_t;

endpackage

`default_nettype wire

// ==== logic/noc_vc_sw_alloc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_router_defines.svh"

module noc_vc_sw_alloc
	import noc_router_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  vc_req_t req [`NOC_P][`NOC_V],
	input  logic [`NOC_V-1:0] ovc_free [`NOC_P],
	input  logic [`NOC_V-1:0] credit_avail [`NOC_P],
	output vc_grant_t grant [`NOC_P][`NOC_V]
);

	localparam int PV = `NOC_P * `NOC_V;
	localparam int PTR_W = $clog2(PV);

	logic [PV-1:0] elig [`NOC_P];
	logic [VC_W-1:0] ovc_pick [PV];
	logic [PTR_W-1:0] rr_ptr [`NOC_P];
	logic [PTR_W-1:0] win_idx [`NOC_P];
	logic [`NOC_P-1:0] found;
	vc_grant_t grant_d [`NOC_P][`NOC_V];
	logic [PV-1:0] port_hits [`NOC_P];

	// which input vcs may go this cycle, and on which output vc
	always_comb begin
		logic [`NOC_V-1:0] ok;
		ok = '0;
		for (int o = 0; o < `NOC_P; o++)
			elig[o] = '0;
		for (int c = 0; c < PV; c++)
			ovc_pick[c] = '0;
		for (int p = 0; p < `NOC_P; p++) begin
			for (int v = 0; v < `NOC_V; v++) begin
				for (int o = 0; o < `NOC_P; o++) begin
					if (req[p][v].valid && req[p][v].dest[o]) begin
						ok = ovc_free[o] & credit_avail[o];
						if (req[p][v].new_vc) begin
							elig[o][p*`NOC_V+v] = |ok;
							// lowest free index wins
							for (int k = `NOC_V - 1; k >= 0; k--)
								if (ok[k])
									ovc_pick[p*`NOC_V+v] = VC_W'(k);
						end else begin
							elig[o][p*`NOC_V+v] = credit_avail[o][req[p][v].ovc];
							ovc_pick[p*`NOC_V+v] = req[p][v].ovc;
						end
					end
				end
			end
		end
	end

	// round robin per output, an input port served once per cycle
	always_comb begin
		logic [`NOC_P-1:0] in_used;
		int c;
		in_used = '0;
		found = '0;
		c = 0;
		for (int o = 0; o < `NOC_P; o++)
			win_idx[o] = '0;
		for (int p = 0; p < `NOC_P; p++)
			for (int v = 0; v < `NOC_V; v++)
				grant_d[p][v] = '0;
		for (int o = 0; o < `NOC_P; o++) begin
			for (int k = 0; k < PV; k++) begin
				c = int'(rr_ptr[o]) + k;
				if (c >= PV)
					c = c - PV;
				if (!found[o] && elig[o][c] && !in_used[c / `NOC_V]) begin
					found[o] = 1'b1;
					win_idx[o] = PTR_W'(c);
				end
			end
			if (found[o]) begin
				c = int'(win_idx[o]);
				in_used[c / `NOC_V] = 1'b1;
				grant_d[c / `NOC_V][c % `NOC_V].granted = 1'b1;
				grant_d[c / `NOC_V][c % `NOC_V].dest = `NOC_P'(1) << o;
				grant_d[c / `NOC_V][c % `NOC_V].ovc = ovc_pick[c];
				grant_d[c / `NOC_V][c % `NOC_V].tail = req[c / `NOC_V][c % `NOC_V].tail;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int o = 0; o < `NOC_P; o++)
				rr_ptr[o] <= '0;
			for (int p = 0; p < `NOC_P; p++)
				for (int v = 0; v < `NOC_V; v++)
					grant[p][v] <= '0;
		end else begin
			// priority moves just past the winner
			for (int o = 0; o < `NOC_P; o++)
				if (found[o])
					rr_ptr[o] <= (win_idx[o] == PTR_W'(PV - 1)) ? '0 : win_idx[o] + 1'b1;
			for (int p = 0; p < `NOC_P; p++)
				for (int v = 0; v < `NOC_V; v++)
					grant[p][v] <= grant_d[p][v];
		end
	end

	always_comb begin
		for (int o = 0; o < `NOC_P; o++)
			for (int p = 0; p < `NOC_P; p++)
				for (int v = 0; v < `NOC_V; v++)
					port_hits[o][p*`NOC_V+v] = grant[p][v].granted && grant[p][v].dest[o];
	end

	for (genvar o = 0; o < `NOC_P; o++) begin : g_chk
		a_one_grant: assert property (
			@(posedge clk) disable iff (reset) $onehot0(port_hits[o])
		);
	end

endmodule

`default_nettype wire

// ==== noc_router.f ====
+incdir+include
logic/noc_router_pkg.sv
logic/credit_release_gen.sv
logic/noc_input_port.sv
logic/noc_vc_sw_alloc.sv
logic/noc_output_port.sv
logic/noc_router.sv
verif/noc_tb_clock.sv
verif/noc_router_checker.sv
verif/noc_router_tb.sv

// ==== verif/noc_router_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_router_defines.svh"

module noc_router_checker
	import noc_router_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  flit_chan_t chan_in [`NOC_P],
	input  flit_chan_t chan_out [`NOC_P],
	input  logic [`NOC_V-1:0] release_en,
	input  logic [`NOC_P-1:0] hold,
	input  logic exp_wr,
	input  flit_t exp_flit,
	input  logic [2:0] exp_port,
	input  logic [4:0] exp_len,
	input  logic exp_lat,
	input  logic finish,
	output int val_errs,
	output int other_errs,
	output logic all_rcvd
);

	localparam int MAXP = 16;
	localparam int MAXF = 16;
	// write sampled on one edge, output strobe set two edges later, taken one edge after that
	localparam int LAT_SAMPLES = 3;

	logic [`NOC_FW-1:0] exp_word [MAXP][MAXF];
	int exp_dst [MAXP];
	int exp_n [MAXP];
	logic lat_chk [MAXP];
	int rcv_cnt [MAXP];
	int w_cyc [MAXP];
	int pkt_ovc [MAXP];
	int owner [`NOC_P][`NOC_V];
	int dcred [`NOC_P][`NOC_V];
	int wr_cnt [`NOC_P][`NOC_V];
	int cr_cnt [`NOC_P][`NOC_V];
	int hold_flits [`NOC_P];
	logic [`NOC_P-1:0] hold_q;
	int rel_cnt [`NOC_V];
	int rel_win [`NOC_V];
	int cyc;
	int n_exp;
	int n_rcv;

	assign all_rcvd = (n_exp > 0) && (n_rcv == n_exp);

	task automatic report_value(input string name, input logic [31:0] expv,
			input logic [31:0] actv);
		$display("** Error at %0t: %s expected %0h, got %0h", $time, name, expv, actv);
		val_errs++;
	endtask

	task automatic report_other(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		other_errs++;
	endtask

	// score one flit seen on an output port
	task automatic check_flit(input int o, input int v, input flit_t f);
		int pkt;
		int idx;
		pkt = int'(f[11:4]);
		idx = int'(f[3:0]);
		if (pkt >= MAXP || exp_n[pkt] == 0) begin
			report_other($sformatf("unexpected flit %h on chan_out[%0d]", f, o));
		end else begin
			if (o != exp_dst[pkt])
				report_value($sformatf("output port of packet %0d", pkt), exp_dst[pkt], o);
			if (idx != rcv_cnt[pkt])
				report_value($sformatf("flit index of packet %0d", pkt), rcv_cnt[pkt], idx);
			else if (f != exp_word[pkt][idx])
				report_value($sformatf("chan_out[%0d].flit", o), exp_word[pkt][idx], f);
			if (dcred[o][v] == 0)
				report_other($sformatf("flit on chan_out[%0d] vc %0d without credit", o, v));
			else
				dcred[o][v]--;
			if (idx == 0) begin
				if (owner[o][v] >= 0)
					report_other($sformatf("head of packet %0d on owned vc %0d of port %0d",
						pkt, v, o));
				owner[o][v] = pkt;
				pkt_ovc[pkt] = v;
				if (lat_chk[pkt] && cyc - w_cyc[pkt] != LAT_SAMPLES)
					report_value("chan_out latency", LAT_SAMPLES, cyc - w_cyc[pkt]);
			end else if (v != pkt_ovc[pkt]) begin
				report_value($sformatf("chan_out[%0d].vc", o), pkt_ovc[pkt], v);
			end
			if (idx == exp_n[pkt] - 1)
				owner[o][v] = -1;
			rcv_cnt[pkt]++;
			n_rcv++;
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			cyc = 0;
			n_exp = 0;
			n_rcv = 0;
			val_errs = 0;
			other_errs = 0;
			hold_q = '0;
			for (int k = 0; k < MAXP; k++) begin
				exp_n[k] = 0;
				rcv_cnt[k] = 0;
				lat_chk[k] = 1'b0;
			end
			for (int p = 0; p < `NOC_P; p++) begin
				hold_flits[p] = 0;
				for (int v = 0; v < `NOC_V; v++) begin
					owner[p][v] = -1;
					dcred[p][v] = `NOC_LB;
					wr_cnt[p][v] = 0;
					cr_cnt[p][v] = 0;
				end
			end
			for (int v = 0; v < `NOC_V; v++) begin
				rel_cnt[v] = 0;
				rel_win[v] = 0;
			end
		end else begin
			cyc++;
			if (exp_wr) begin
				exp_word[exp_flit[11:4]][exp_flit[3:0]] = exp_flit;
				exp_dst[exp_flit[11:4]] = exp_port;
				exp_n[exp_flit[11:4]] = exp_len;
				lat_chk[exp_flit[11:4]] = exp_lat;
				n_exp++;
			end
			for (int p = 0; p < `NOC_P; p++) begin
				for (int v = 0; v < `NOC_V; v++) begin
					if (chan_in[p].flit_wr && chan_in[p].vc == VC_W'(v)) begin
						wr_cnt[p][v]++;
						if (chan_in[p].flit[3:0] == 4'd0 && chan_in[p].flit[11:4] < MAXP)
							w_cyc[chan_in[p].flit[11:4]] = cyc;
					end
					if (chan_in[p].credit[v])
						dcred[p][v]++;
					if (chan_out[p].credit[v])
						cr_cnt[p][v]++;
				end
				if (chan_out[p].flit_wr) begin
					check_flit(p, int'(chan_out[p].vc), chan_out[p].flit);
					if (hold[p])
						hold_flits[p]++;
				end
				if (hold[p] && !hold_q[p])
					hold_flits[p] = 0;
				// held port drains exactly one buffer of credits
				if (hold_q[p] && !hold[p] && hold_flits[p] != `NOC_LB)
					report_value($sformatf("flits on chan_out[%0d] while held", p),
						`NOC_LB, hold_flits[p]);
			end
			hold_q = hold;
			for (int v = 0; v < `NOC_V; v++) begin
				if (release_en[v]) begin
					rel_cnt[v]++;
					rel_win[v] = `NOC_LB + 1;
				end else if (rel_win[v] > 0) begin
					if (chan_out[`NOC_PORT_LOCAL].credit[v] != (rel_win[v] > 1))
						report_value($sformatf("chan_out[0].credit[%0d]", v),
							rel_win[v] > 1, chan_out[`NOC_PORT_LOCAL].credit[v]);
					rel_win[v]--;
				end
			end
			if (finish) begin
				for (int k = 0; k < MAXP; k++)
					if (rcv_cnt[k] != exp_n[k])
						report_other($sformatf("packet %0d: %0d of %0d flits arrived",
							k, rcv_cnt[k], exp_n[k]));
				for (int p = 0; p < `NOC_P; p++)
					for (int v = 0; v < `NOC_V; v++)
						if (cr_cnt[p][v] != wr_cnt[p][v] +
								((p == `NOC_PORT_LOCAL) ? rel_cnt[v] * `NOC_LB : 0))
							report_value($sformatf("credits on chan_out[%0d] vc %0d", p, v),
								wr_cnt[p][v] + ((p == `NOC_PORT_LOCAL) ?
								rel_cnt[v] * `NOC_LB : 0), cr_cnt[p][v]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/noc_router_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_router_defines.svh"

module noc_router_tb
	import noc_router_pkg::*;
();

	typedef struct packed {
		logic [2:0] port;
		logic vc;
		logic [3:0] dx;
		logic [3:0] dy;
		logic [4:0] len;
		logic [5:0] gap;
		logic [2:0] exp_port;
		logic hold;
		logic lat;
	} row_t;

	logic clk;
	logic reset;
	logic [`NOC_V-1:0] credit_release_en;
	flit_chan_t chan_in [`NOC_P];
	flit_chan_t chan_out [`NOC_P];
	logic up_wr [`NOC_P];
	logic [VC_W-1:0] up_vc [`NOC_P];
	flit_t up_flit [`NOC_P];
	logic [`NOC_V-1:0] dn_credit [`NOC_P];
	int up_ret [`NOC_P][`NOC_V];
	int up_used [`NOC_P][`NOC_V];
	int pend [`NOC_P][`NOC_V];
	row_t table_q [$];
	int cycle;
	int limit;
	int hold_until;
	int hold_port;
	logic [`NOC_P-1:0] hold_vec;
	logic [15:0] lfsr;
	logic exp_wr;
	flit_t exp_flit;
	logic [2:0] exp_port;
	logic [4:0] exp_len;
	logic exp_lat;
	logic finish;
	int val_errs;
	int other_errs;
	logic all_rcvd;

	noc_tb_clock #(.PERIOD(40)) u_clock (.clk(clk));

	noc_router UUT (
		.clk(clk),
		.reset(reset),
		.current_x(4'd2),
		.current_y(4'd2),
		.credit_release_en(credit_release_en),
		.chan_in(chan_in),
		.chan_out(chan_out)
	);

	noc_router_checker u_checker (
		.clk(clk),
		.reset(reset),
		.chan_in(chan_in),
		.chan_out(chan_out),
		.release_en(credit_release_en),
		.hold(hold_vec),
		.exp_wr(exp_wr),
		.exp_flit(exp_flit),
		.exp_port(exp_port),
		.exp_len(exp_len),
		.exp_lat(exp_lat),
		.finish(finish),
		.val_errs(val_errs),
		.other_errs(other_errs),
		.all_rcvd(all_rcvd)
	);

	always_comb begin
		for (int p = 0; p < `NOC_P; p++) begin
			chan_in[p].flit_wr = up_wr[p];
			chan_in[p].vc = up_vc[p];
			chan_in[p].flit = up_flit[p];
			chan_in[p].credit = dn_credit[p];
		end
	end

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic flit_t make_flit(input row_t r, input int pkt, input int idx);
		flit_t f;
		flit_type_e t;
		if (r.len == 1)
			t = SINGLE;
		else if (idx == 0)
			t = HEAD;
		else if (idx == r.len - 1)
			t = TAIL;
		else
			t = BODY;
		if (t == HEAD || t == SINGLE) begin
			f.head.ftype = t;
			f.head.dst_x = r.dx;
			f.head.dst_y = r.dy;
			f.head.src_x = 4'd0;
			f.head.src_y = 4'(r.port);
			f.head.payload = {2'b00, 8'(pkt), 4'(idx)};
		end else begin
			f.body.ftype = t;
			f.body.payload = {18'h2b5a3 ^ 18'(idx * 7), 8'(pkt), 4'(idx)};
		end
		return f;
	endfunction

	task automatic add_row(input int port, input int vc, input int dx, input int dy,
			input int len, input int gap, input int exp_p, input bit hold, input bit lat);
		row_t r;
		r = '{3'(port), 1'(vc), 4'(dx), 4'(dy), 5'(len), 6'(gap), 3'(exp_p), hold, lat};
		table_q.push_back(r);
	endtask

	task automatic clear_strobes();
		for (int p = 0; p < `NOC_P; p++)
			up_wr[p] = 1'b0;
		exp_wr = 1'b0;
		credit_release_en = '0;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#5;
		clear_strobes();
	endtask

	// upstream side writes only while holding a credit
	task automatic send_flit(input row_t r, input int pkt, input int idx);
		@(posedge clk);
		#5;
		clear_strobes();
		while (`NOC_LB + up_ret[r.port][r.vc] - up_used[r.port][r.vc] <= 0) begin
			@(posedge clk);
			#5;
		end
		up_wr[r.port] = 1'b1;
		up_vc[r.port] = r.vc;
		up_flit[r.port] = make_flit(r, pkt, idx);
		up_used[r.port][r.vc]++;
		exp_wr = 1'b1;
		exp_flit = make_flit(r, pkt, idx);
		exp_port = r.exp_port;
		exp_len = r.len;
		exp_lat = r.lat;
	endtask

	always @(posedge clk) begin
		for (int p = 0; p < `NOC_P; p++)
			for (int v = 0; v < `NOC_V; v++)
				if (reset)
					up_ret[p][v] = 0;
				else if (chan_out[p].credit[v])
					up_ret[p][v]++;
	end

	always @(posedge clk) begin
		cycle++;
		if (limit > 0 && cycle >= limit) begin
			$display("timeout: run still busy after %0d cycles", limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// downstream credits go back at random unless the port is held
	initial begin
		lfsr = 16'd44000;
		hold_vec = '0;
		for (int p = 0; p < `NOC_P; p++) begin
			dn_credit[p] = '0;
			for (int v = 0; v < `NOC_V; v++)
				pend[p][v] = 0;
		end
		forever begin
			@(posedge clk);
			for (int o = 0; o < `NOC_P; o++)
				for (int v = 0; v < `NOC_V; v++)
					if (!reset && chan_out[o].flit_wr && chan_out[o].vc == VC_W'(v))
						pend[o][v]++;
			#5;
			for (int o = 0; o < `NOC_P; o++) begin
				hold_vec[o] = (cycle < hold_until) && (o == hold_port);
				for (int v = 0; v < `NOC_V; v++) begin
					dn_credit[o][v] = 1'b0;
					if (!hold_vec[o] && pend[o][v] > 0) begin
						lfsr = lfsr_step(lfsr);
						if (lfsr[0]) begin
							dn_credit[o][v] = 1'b1;
							pend[o][v]--;
						end
					end
				end
			end
		end
	end

	initial begin
		int total;
		int pkt;
		reset = 1'b1;
		finish = 1'b0;
		cycle = 0;
		limit = 0;
		hold_until = 0;
		hold_port = 0;
		exp_flit = '0;
		exp_port = '0;
		exp_len = '0;
		exp_lat = 1'b0;
		for (int p = 0; p < `NOC_P; p++) begin
			up_vc[p] = '0;
			up_flit[p] = '0;
			for (int v = 0; v < `NOC_V; v++)
				up_used[p][v] = 0;
		end
		clear_strobes();
		// port vc dx dy len gap out hold lat
		// router sits at (2,2)
		add_row(0, 0, 2, 2, 1, 0, 0, 0, 1);
		add_row(3, 0, 4, 2, 3, 2, 1, 0, 0);
		add_row(1, 1, 0, 3, 2, 1, 3, 0, 0);
		add_row(4, 0, 2, 3, 4, 1, 2, 0, 0);
		add_row(2, 1, 2, 0, 3, 0, 4, 0, 0);
		add_row(0, 1, 3, 1, 2, 0, 1, 0, 0);
		// three heads for the north port
		add_row(1, 0, 2, 4, 5, 4, 2, 0, 0);
		add_row(3, 1, 2, 5, 5, 0, 2, 0, 0);
		add_row(0, 0, 2, 3, 5, 0, 2, 0, 0);
		add_row(4, 1, 1, 2, 2, 0, 3, 0, 0);
		add_row(3, 0, 2, 0, 10, 30, 4, 1, 0);
		add_row(2, 0, 2, 2, 3, 4, 0, 0, 0);
		add_row(1, 1, 5, 5, 1, 0, 1, 0, 0);
		total = 0;
		foreach (table_q[i])
			total += table_q[i].len + table_q[i].gap;
		limit = 20 * total;
		repeat (2) @(posedge clk);
		#5;
		reset = 1'b0;
		pkt = 0;
		foreach (table_q[i]) begin
			repeat (table_q[i].gap) idle_cycle();
			if (table_q[i].hold) begin
				hold_port = table_q[i].exp_port;
				hold_until = cycle + 40;
			end
			for (int k = 0; k < table_q[i].len; k++)
				send_flit(table_q[i], pkt, k);
			pkt++;
		end
		idle_cycle();
		while (!all_rcvd)
			idle_cycle();
		repeat (20) idle_cycle();
		credit_release_en[0] = 1'b1;
		repeat (12) idle_cycle();
		finish = 1'b1;
		idle_cycle();
		finish = 1'b0;
		idle_cycle();
		$display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/noc_tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module noc_tb_clock #(
	parameter int PERIOD = 40
)(
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire
